//--- rtl/cpuPkg.sv
package cpuPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0] regIdxT;

    typedef enum logic [3:0] {
        opBne   = 4'd0,
        opBeq   = 4'd1,
        opAdi   = 4'd4,
        opLwd   = 4'd7,
        opSwd   = 4'd8,
        opJmp   = 4'd9,
        opRtype = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        funcAdd = 6'd0,
        funcSub = 6'd1,
        funcAnd = 6'd2,
        funcOrr = 6'd3,
        funcWwd = 6'd28,
        funcHlt = 6'd29
    } funcT;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOr} aluOpT;

    typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

    typedef struct packed {
        wordT pc;
        wordT instr;
        logic valid;
    } ifIdT;

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrcImm;
        logic  isWwd;
        logic  isHalt;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        regIdxT rs;
        regIdxT rt;
        regIdxT dest;
        wordT   rsVal;
        wordT   rtVal;
        wordT   imm;
        logic   valid;
    } idExT;

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   isWwd;
        logic   isHalt;
        wordT   aluRes;     // also the data address
        wordT   storeData;
        wordT   wwdVal;
        regIdxT dest;
        logic   valid;
    } exMemT;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   isWwd;
        logic   isHalt;
        wordT   loadData;
        wordT   aluRes;
        wordT   wwdVal;
        regIdxT dest;
        logic   valid;
    } memWbT;

    // value written back, shared by WB and the EX forward path
    function automatic wordT wbValue(memWbT w);
        return w.memToReg ? w.loadData : w.aluRes;
    endfunction

endpackage

//--- rtl/regFile.sv
module regFile import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  regIdxT rs,
    input  regIdxT rt,
    input  logic   wbEn,
    input  regIdxT wbIdx,
    input  wordT   wbData,
    output wordT   rdA,
    output wordT   rdB
);

    wordT regs [4];

    // write-first bypass
    assign rdA = (wbEn && wbIdx == rs) ? wbData : regs[rs];
    assign rdB = (wbEn && wbIdx == rt) ? wbData : regs[rt];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++)
                regs[i] <= '0;
        end else if (wbEn) begin
            regs[wbIdx] <= wbData;
        end
    end

endmodule

//--- rtl/fetchStage.sv
module fetchStage import cpuPkg::*; #(
    parameter wordT resetPc = '0
) (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic redirect,
    input  wordT redirectPc,
    input  logic haltSeen,
    input  wordT instrData,
    output logic instrRead,
    output wordT instrAddr,
    output ifIdT ifId
);

    wordT pc;
    logic fetchOn;  // low for the first cycle out of reset

    assign instrRead = fetchOn && !haltSeen;
    assign instrAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
            fetchOn <= 1'b0;
            ifId <= '0;
        end else begin
            fetchOn <= 1'b1;
            if (redirect) begin
                pc <= redirectPc;
                ifId.valid <= 1'b0;     // flush the slot fetched behind the branch
            end else if (stall) begin
                // hold pc and ifId
            end else if (!instrRead) begin
                ifId.valid <= 1'b0;
            end else begin
                ifId.pc <= pc;
                ifId.instr <= instrData;
                ifId.valid <= 1'b1;
                pc <= pc + 16'd1;
            end
        end
    end

    // a held decode slot waits at most two cycles for its operands
    assert property (@(posedge clk) disable iff (rst) (stall && $past(stall)) |=> !stall)
        else $error("fetch frozen for more than two cycles");

endmodule

//--- rtl/decodeStage.sv
module decodeStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  ifIdT   ifId,
    input  logic   stall,
    input  wordT   rdA,
    input  wordT   rdB,
    output regIdxT rs,
    output regIdxT rt,
    output idExT   idEx,
    output logic   redirect,
    output wordT   redirectPc,
    output logic   haltSeen
);

    opcodeT opcode;
    funcT   func;
    regIdxT rdIdx;
    regIdxT dest;
    wordT   imm;
    wordT   pcPlus1;
    ctrlT   ctrl;
    logic   isBranch, isJump, taken, hltNow, haltReg;

    assign opcode = opcodeT'(ifId.instr[15:12]);
    assign func = funcT'(ifId.instr[5:0]);
    assign rs = ifId.instr[11:10];
    assign rt = ifId.instr[9:8];
    assign rdIdx = ifId.instr[7:6];
    assign imm = {{8{ifId.instr[7]}}, ifId.instr[7:0]};
    assign pcPlus1 = ifId.pc + 16'd1;

    always_comb begin
        ctrl = '0;
        dest = rdIdx;
        isBranch = 1'b0;
        isJump = 1'b0;
        case (opcode)
            opRtype: begin
                case (func)
                    funcAdd: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluAdd; end
                    funcSub: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluSub; end
                    funcAnd: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluAnd; end
                    funcOrr: begin ctrl.regWrite = 1'b1; ctrl.aluOp = aluOr; end
                    funcWwd: ctrl.isWwd = 1'b1;
                    funcHlt: ctrl.isHalt = 1'b1;
                    default: ;
                endcase
            end
            opAdi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                dest = rt;
            end
            opLwd: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                dest = rt;
            end
            opSwd: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBne, opBeq: isBranch = 1'b1;
            opJmp: isJump = 1'b1;
            default: ;
        endcase
    end

    // branch target is pc+1+imm, jump keeps the top nibble of pc+1
    assign taken = isBranch && ((opcode == opBeq) == (rdA == rdB));
    assign redirect = ifId.valid && !stall && (isJump || taken);
    assign redirectPc = isJump ? {pcPlus1[15:12], ifId.instr[11:0]} : pcPlus1 + imm;

    assign hltNow = ifId.valid && !stall && ctrl.isHalt;
    assign haltSeen = haltReg || hltNow;

    always_ff @(posedge clk) begin
        if (rst) begin
            haltReg <= 1'b0;
            idEx <= '0;
        end else begin
            if (hltNow)
                haltReg <= 1'b1;
            if (stall || !ifId.valid) begin
                idEx <= '0;     // bubble
            end else begin
                idEx.ctrl <= ctrl;
                idEx.rs <= rs;
                idEx.rt <= rt;
                idEx.dest <= dest;
                idEx.rsVal <= rdA;
                idEx.rtVal <= rdB;
                idEx.imm <= imm;
                idEx.valid <= 1'b1;
            end
        end
    end

    // fetch must only feed bubbles once HLT has gone through decode
    assert property (@(posedge clk) disable iff (rst) haltReg |-> !ifId.valid)
        else $error("valid instruction in decode after halt");

endmodule

//--- rtl/hazardUnit.sv
module hazardUnit import cpuPkg::*; (
    input  ifIdT   ifId,
    input  idExT   idEx,
    input  exMemT  exMem,
    input  memWbT  memWb,
    output logic   stall,
    output fwdSelT fwdA,
    output fwdSelT fwdB
);

    opcodeT op;
    regIdxT rs, rt;
    logic   isBranch, usesRs, usesRt, loadUse, branchStall, exHit, memHit;

    assign op = opcodeT'(ifId.instr[15:12]);
    assign rs = ifId.instr[11:10];
    assign rt = ifId.instr[9:8];
    assign isBranch = (op == opBne) || (op == opBeq);
    assign usesRs = (op != opJmp);
    assign usesRt = (op == opRtype) || (op == opSwd) || isBranch;

    function automatic logic srcHit(regIdxT d, regIdxT s, regIdxT t, logic useS, logic useT);
        return (useS && d == s) || (useT && d == t);
    endfunction

    function automatic fwdSelT pickFwd(regIdxT src, exMemT m, memWbT w);
        if (m.valid && m.regWrite && m.dest == src)
            return fwdMem;      // youngest producer wins
        if (w.valid && w.regWrite && w.dest == src)
            return fwdWb;
        return fwdReg;
    endfunction

    assign exHit = srcHit(idEx.dest, rs, rt, usesRs, usesRt);
    assign memHit = srcHit(exMem.dest, rs, rt, usesRs, usesRt);

    assign loadUse = ifId.valid && idEx.valid && idEx.ctrl.memRead && exHit;
    assign branchStall = ifId.valid && isBranch &&
        ((idEx.valid && idEx.ctrl.regWrite && exHit) ||
         (exMem.valid && exMem.regWrite && memHit));

    assign stall = loadUse || branchStall;
    assign fwdA = pickFwd(idEx.rs, exMem, memWb);
    assign fwdB = pickFwd(idEx.rt, exMem, memWb);

endmodule

//--- rtl/executeStage.sv
module executeStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  idExT   idEx,
    input  fwdSelT fwdA,
    input  fwdSelT fwdB,
    input  memWbT  memWbFwd,
    output exMemT  exMem
);

    wordT rsFwd, rtFwd, opB, aluRes, wbFwd;

    function automatic wordT pick(fwdSelT sel, wordT regVal, wordT memVal, wordT wbVal);
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign wbFwd = wbValue(memWbFwd);
    assign rsFwd = pick(fwdA, idEx.rsVal, exMem.aluRes, wbFwd);
    assign rtFwd = pick(fwdB, idEx.rtVal, exMem.aluRes, wbFwd);
    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluAdd:  aluRes = rsFwd + opB;
            aluSub:  aluRes = rsFwd - opB;
            aluAnd:  aluRes = rsFwd & opB;
            default: aluRes = rsFwd | opB;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem.regWrite <= idEx.ctrl.regWrite;
            exMem.memRead <= idEx.ctrl.memRead;
            exMem.memWrite <= idEx.ctrl.memWrite;
            exMem.memToReg <= idEx.ctrl.memToReg;
            exMem.isWwd <= idEx.ctrl.isWwd;
            exMem.isHalt <= idEx.ctrl.isHalt;
            exMem.aluRes <= aluRes;
            exMem.storeData <= rtFwd;
            exMem.wwdVal <= rsFwd;      // WWD prints rs
            exMem.dest <= idEx.dest;
            exMem.valid <= idEx.valid;
        end
    end

endmodule

//--- rtl/memWbStage.sv
module memWbStage import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  exMemT  exMem,
    input  wordT   dataRdata,
    output logic   dataRead,
    output logic   dataWrite,
    output wordT   dataAddr,
    output wordT   dataWdata,
    output memWbT  memWb,
    output logic   wbEn,
    output regIdxT wbIdx,
    output wordT   wbData,
    output wordT   outputPort,
    output logic   outputValid,
    output wordT   numInst,
    output logic   halted
);

    assign dataRead = exMem.valid && exMem.memRead;
    assign dataWrite = exMem.valid && exMem.memWrite;
    assign dataAddr = exMem.aluRes;
    assign dataWdata = exMem.storeData;

    assign wbEn = memWb.valid && memWb.regWrite;
    assign wbIdx = memWb.dest;
    assign wbData = wbValue(memWb);

    always_ff @(posedge clk) begin
        if (rst) begin
            memWb <= '0;
            outputValid <= 1'b0;
            outputPort <= '0;
            numInst <= '0;
            halted <= 1'b0;
        end else begin
            memWb <= '{exMem.regWrite, exMem.memToReg, exMem.isWwd, exMem.isHalt,
                       dataRdata, exMem.aluRes, exMem.wwdVal, exMem.dest, exMem.valid};
            outputValid <= memWb.valid && memWb.isWwd;
            if (memWb.valid && memWb.isWwd)
                outputPort <= memWb.wwdVal;
            if (memWb.valid)
                numInst <= numInst + 16'd1;     // retire count, HLT included
            if (memWb.valid && memWb.isHalt)
                halted <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(dataRead && dataWrite))
        else $error("load and store in MEM at once");

endmodule

//--- rtl/cpuCore.sv
module cpuCore import cpuPkg::*; #(
    parameter wordT resetPc = '0
) (
    input  logic clk,
    input  logic rst,
    // instruction port
    output logic instrRead,
    output wordT instrAddr,
    input  wordT instrData,
    // data port
    output logic dataRead,
    output logic dataWrite,
    output wordT dataAddr,
    output wordT dataWdata,
    input  wordT dataRdata,
    // debug
    output wordT outputPort,
    output logic outputValid,
    output wordT numInst,
    output logic halted
);

    ifIdT   ifId;
    idExT   idEx;
    exMemT  exMem;
    memWbT  memWb;
    logic   stall;
    fwdSelT fwdA, fwdB;
    logic   redirect, haltSeen;
    wordT   redirectPc;
    regIdxT rs, rt, wbIdx;
    wordT   rdA, rdB, wbData;
    logic   wbEn;

    fetchStage #(.resetPc(resetPc)) fetch (
        .clk, .rst, .stall, .redirect, .redirectPc, .haltSeen,
        .instrData, .instrRead, .instrAddr, .ifId
    );

    decodeStage decode (
        .clk, .rst, .ifId, .stall, .rdA, .rdB, .rs, .rt,
        .idEx, .redirect, .redirectPc, .haltSeen
    );

    regFile regs (
        .clk, .rst, .rs, .rt, .wbEn, .wbIdx, .wbData, .rdA, .rdB
    );

    hazardUnit hazard (
        .ifId, .idEx, .exMem, .memWb, .stall, .fwdA, .fwdB
    );

    executeStage execute (
        .clk, .rst, .idEx, .fwdA, .fwdB, .memWbFwd(memWb), .exMem
    );

    memWbStage memWbSt (
        .clk, .rst, .exMem, .dataRdata, .dataRead, .dataWrite, .dataAddr,
        .dataWdata, .memWb, .wbEn, .wbIdx, .wbData, .outputPort,
        .outputValid, .numInst, .halted
    );

endmodule

//--- dv/cpuModel.sv
package cpuModel;
    import cpuPkg::*;

    typedef struct packed {
        wordT addr;
        wordT data;
    } storeT;

    integer seed = 32'hba5e0008;
    wordT   prog [256];
    int     progLen;
    wordT   expWwd [$];
    storeT  expStores [$];
    wordT   expCount;

    function automatic wordT encR(int f, int rs, int rt, int rd);
        return {opRtype, rs[1:0], rt[1:0], rd[1:0], f[5:0]};
    endfunction

    function automatic wordT encI(opcodeT op, int rs, int rt, int imm);
        return {op, rs[1:0], rt[1:0], imm[7:0]};
    endfunction

    function automatic wordT encJ(int target);
        return {opJmp, target[11:0]};
    endfunction

    task automatic clearProg();
        foreach (prog[i])
            prog[i] = '0;
        progLen = 0;
    endtask

    task automatic put(wordT w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic loadDirected(int k);
        clearProg();
        case (k)
            0: begin    // back-to-back dependent ALU ops
                put(encI(opAdi, 0, 1, 5));
                put(encI(opAdi, 1, 2, 8'hfe));
                put(encR(funcAdd, 1, 2, 3));
                put(encR(funcSub, 3, 1, 3));
                put(encR(funcOrr, 3, 2, 0));
                put(encR(funcWwd, 3, 0, 0));
                put(encR(funcWwd, 0, 0, 0));
            end
            1: begin    // load then use
                put(encI(opAdi, 0, 1, 7));
                put(encI(opAdi, 0, 2, 8'h20));
                put(encI(opSwd, 2, 1, 1));
                put(encI(opLwd, 2, 3, 1));
                put(encR(funcAdd, 3, 3, 0));
                put(encR(funcWwd, 0, 0, 0));
            end
            2: begin    // branch on a register the previous load writes
                put(encI(opAdi, 0, 1, 9));
                put(encI(opSwd, 0, 1, 4));
                put(encI(opLwd, 0, 2, 4));
                put(encI(opBeq, 2, 1, 1));
                put(encI(opAdi, 0, 3, 1));
                put(encR(funcWwd, 3, 0, 0));
            end
            default: begin  // writers sitting in the flushed slot
                put(encI(opAdi, 0, 1, 1));
                put(encI(opBne, 1, 0, 1));
                put(encI(opAdi, 0, 2, 8'h55));
                put(encJ(5));
                put(encI(opAdi, 0, 2, 8'h66));
                put(encR(funcWwd, 2, 0, 0));
            end
        endcase
        put(encR(funcHlt, 0, 0, 0));
    endtask

    // forward-only control flow, HLT last, so every program ends
    task automatic genProgram(int maxLen);
        int   n, kind, off, rnd;
        wordT ins;
        clearProg();
        n = 8 + {$random(seed)} % (maxLen - 7);
        for (int i = 0; i < n - 1; i++) begin
            rnd = $random(seed);
            ins = rnd[15:0];
            kind = {$random(seed)} % 16;
            off = {$random(seed)} % 4;
            if (i + 1 + off > n - 1)
                off = n - 2 - i;
            if (kind < 5) begin
                ins[15:12] = opRtype;
                ins[5:2] = 4'd0;    // add, sub, and, or
            end else if (kind < 8) begin
                ins[15:12] = opAdi;
            end else if (kind < 10) begin
                ins[15:12] = opLwd;
            end else if (kind < 12) begin
                ins[15:12] = opSwd;
            end else if (kind == 12) begin
                ins[15:12] = opRtype;
                ins[5:0] = funcWwd;
            end else if (kind < 15) begin
                ins[15:12] = ins[0] ? opBeq : opBne;
                ins[7:0] = off[7:0];
            end else begin
                ins = encJ(i + 1 + off);
            end
            put(ins);
        end
        rnd = $random(seed);
        ins = rnd[15:0];
        ins[15:12] = opRtype;
        ins[5:0] = funcHlt;
        put(ins);
    endtask

    // one instruction at a time, no pipeline
    task automatic runModel();
        wordT       r [4];
        wordT       dm [wordT];
        wordT       ins, imm, addr, pc;
        logic [1:0] rs, rt, rd;
        storeT      st;
        logic       done;
        expWwd.delete();
        expStores.delete();
        expCount = '0;
        foreach (r[i])
            r[i] = '0;
        pc = '0;
        done = 1'b0;
        while (!done) begin
            ins = prog[pc[7:0]];
            rs = ins[11:10];
            rt = ins[9:8];
            rd = ins[7:6];
            imm = {{8{ins[7]}}, ins[7:0]};
            addr = r[rs] + imm;
            expCount = expCount + 16'd1;
            pc = pc + 16'd1;
            case (ins[15:12])
                opAdi: r[rt] = addr;
                opLwd: r[rt] = dm.exists(addr) ? dm[addr] : 16'h0000;
                opSwd: begin
                    dm[addr] = r[rt];
                    st.addr = addr;
                    st.data = r[rt];
                    expStores.push_back(st);
                end
                opBne: if (r[rs] != r[rt]) pc = pc + imm;
                opBeq: if (r[rs] == r[rt]) pc = pc + imm;
                opJmp: pc = {pc[15:12], ins[11:0]};
                opRtype: begin
                    case (ins[5:0])
                        funcAdd: r[rd] = r[rs] + r[rt];
                        funcSub: r[rd] = r[rs] - r[rt];
                        funcAnd: r[rd] = r[rs] & r[rt];
                        funcOrr: r[rd] = r[rs] | r[rt];
                        funcWwd: expWwd.push_back(r[rs]);
                        funcHlt: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    endtask

endpackage

//--- dv/cpuCoreTb.sv
module cpuCoreTb import cpuPkg::*, cpuModel::*; ();

    localparam int numDirected = 4;
    localparam int numRandom = 40;
    localparam int maxLen = 48;
    // at most three cycles per instruction, plus reset and pipeline fill
    localparam int cycleLimit = (numDirected + numRandom) * (maxLen * 3 + 20);

    logic  clk, rst;
    logic  instrRead, dataRead, dataWrite, outputValid, halted;
    wordT  instrAddr, instrData, dataAddr, dataWdata, dataRdata;
    wordT  outputPort, numInst;

    wordT  imem [256];
    wordT  dmem [wordT];
    storeT gotStore;
    int    cycles = 0;

    cpuCore #(.resetPc(16'h0000)) DUT (.*);

    always #20 clk = ~clk;

    task automatic failRun(string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkWord(string name, wordT got, wordT exp);
        if (got !== exp)
            failRun($sformatf("mismatch at %0t: %s got %h expected %h",
                              $time, name, got, exp));
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp)
            failRun($sformatf("mismatch at %0t: %s got %b expected %b",
                              $time, name, got, exp));
    endtask

    task automatic checkStore(storeT got, storeT exp);
        if (got !== exp)
            failRun($sformatf("mismatch at %0t: dataAddr/dataWdata got %h/%h expected %h/%h",
                              $time, got.addr, got.data, exp.addr, exp.data));
    endtask

    // memories answer shortly after the edge, addresses are registered
    always @(posedge clk) begin
        #1;
        instrData = imem[instrAddr[7:0]];
        dataRdata = dmem.exists(dataAddr) ? dmem[dataAddr] : 16'h0000;
    end

    always @(negedge clk) begin
        if (!rst && dataWrite) begin
            gotStore.addr = dataAddr;
            gotStore.data = dataWdata;
            dmem[dataAddr] = dataWdata;
            if (halted)
                failRun("store seen after the core halted");
            else if (expStores.size() == 0)
                failRun("store seen beyond the expected list");
            else
                checkStore(gotStore, expStores.pop_front());
        end
        if (!rst && outputValid) begin
            if (halted)
                failRun("WWD output seen after the core halted");
            else if (expWwd.size() == 0)
                failRun("WWD output seen beyond the expected list");
            else
                checkWord("outputPort", outputPort, expWwd.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit)
            failRun("timeout, the core never halted");
    end

    task automatic runProgram(int k);
        @(posedge clk);
        #1;
        rst = 1'b1;
        if (k < numDirected)
            loadDirected(k);
        else
            genProgram(maxLen);
        runModel();
        foreach (imem[i])
            imem[i] = prog[i];
        dmem.delete();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);     // first fetch not issued yet
        checkBit("instrRead", instrRead, 1'b0);
        checkBit("dataRead", dataRead, 1'b0);
        checkBit("dataWrite", dataWrite, 1'b0);
        checkBit("outputValid", outputValid, 1'b0);
        checkBit("halted", halted, 1'b0);
        checkWord("numInst", numInst, 16'h0000);
        while (!halted)
            @(negedge clk);
        checkWord("numInst", numInst, expCount);
        if (expWwd.size() != 0)
            failRun("core halted with WWD values still expected");
        else if (expStores.size() != 0)
            failRun("core halted with stores still expected");
        repeat (4) @(negedge clk);  // quiet after halt
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instrData = '0;
        dataRdata = '0;
        for (int k = 0; k < numDirected + numRandom; k++)
            runProgram(k);
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- sources.f
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/cpuCore.sv
dv/cpuModel.sv
dv/cpuCoreTb.sv

//--- Bender.yml
package:
  name: cpucore

sources:
  - rtl/cpuPkg.sv
  - rtl/regFile.sv
  - rtl/fetchStage.sv
  - rtl/decodeStage.sv
  - rtl/hazardUnit.sv
  - rtl/executeStage.sv
  - rtl/memWbStage.sv
  - rtl/cpuCore.sv
  - target: simulation
    files:
      - dv/cpuModel.sv
      - dv/cpuCoreTb.sv
